// ==== hw/ghrd_pkg.sv ====
// shared widths, timing defaults and types for the fabric logic
// timing constants assume a 50 MHz fpga_clk_50
// keys are active low everywhere, 0 means pressed
// hps_reset_req_t bit order follows reset_kind_e, cold in bit 0

package ghrd_pkg;

  // ==========================================================================
  // board widths
  // ==========================================================================
  localparam int unsigned num_keys     = 4;
  localparam int unsigned num_switches = 10;

  // ==========================================================================
  // timing defaults
  // ==========================================================================
  localparam int unsigned default_debounce_cycles = 50_000;  // 1 ms at 50 MHz
  localparam int unsigned debounce_count_width    = 16;      // holds debounce_cycles

  localparam int unsigned default_heartbeat_half_period = 25_000_000;  // 0.5 s

  // request pulse lengths seen by the HPS reset manager
  localparam int unsigned cold_pulse_cycles  = 6;
  localparam int unsigned warm_pulse_cycles  = 2;
  localparam int unsigned debug_pulse_cycles = 32;

  // ==========================================================================
  // types
  // ==========================================================================

  // one bit per push key, 0 = pressed
  typedef logic [num_keys-1:0] key_vec_t;

  // reset request kinds, value is the bit position in hps_reset_req_t
  typedef enum logic [1:0] {
    reset_cold  = 2'd0,
    reset_warm  = 2'd1,
    reset_debug = 2'd2
  } reset_kind_e;

  // three reset requests
  // used both as raw active-high input and as active-low output
  typedef struct packed {
    logic debug;  // bit 2
    logic warm;   // bit 1
    logic cold;   // bit 0
  } hps_reset_req_t;

  // event word for the STM trace input, 14 bits
  typedef struct packed {
    logic [num_switches-1:0] switches;  // upper field
    key_vec_t                keys;      // debounced, active low
  } stm_event_t;

endpackage

// ==== hw/key_debounce.sv ====
// debounces num_keys push keys and keeps their active-low polarity
// inputs pass a two-flop synchronizer first, so key may be asynchronous
// debounce_cycles must lie in 1 .. 2**debounce_count_width
// a new level shows up debounce_cycles+2 clock edges after it reaches the pin
// pulses shorter than debounce_cycles never reach debounced_key

`timescale 1ns/1ps

module key_debounce #(
  parameter int unsigned debounce_cycles = ghrd_pkg::default_debounce_cycles
) (
  input  logic               fpga_clk_50,
  input  logic               hps_fpga_reset_n,
  input  ghrd_pkg::key_vec_t key,
  output ghrd_pkg::key_vec_t debounced_key
);

  import ghrd_pkg::*;

  // last count before the held level flips
  localparam logic [debounce_count_width-1:0] count_last =
    debounce_count_width'(debounce_cycles - 1);

  // ==========================================================================
  // synchronizer
  // ==========================================================================
  key_vec_t key_meta;  // first stage that may go metastable
  key_vec_t key_sync;  // safe to use
  key_vec_t key_held;  // accepted level

  // per-key counter of cycles where sync level differs from held level
  logic [debounce_count_width-1:0] diff_cnt [num_keys];

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;  // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ==========================================================================
  // stability counters
  // ==========================================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_held <= '1;
      for (int i = 0; i < num_keys; i++)
      begin
        diff_cnt[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < num_keys; i++)
      begin
        if (key_sync[i] == key_held[i])
        begin
          // back at the held level so any partial count is dropped
          diff_cnt[i] <= '0;
        end
        else if (diff_cnt[i] == count_last)
        begin
          key_held[i] <= key_sync[i];  // stable long enough
          diff_cnt[i] <= '0;
        end
        else
        begin
          diff_cnt[i] <= diff_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign debounced_key = key_held;

endmodule

// ==== hw/reset_pulse_gen.sv ====
// turns a rising edge on req_in into a pulse of pulse_cycles cycles
// one instance per reset_kind_e request (cold, warm, debug)
// req_in must already be synchronous to fpga_clk_50
// edges during a running pulse are dropped, the pulse is never restarted
// a request already high when reset releases gives no pulse

`timescale 1ns/1ps

module reset_pulse_gen #(
  parameter int unsigned pulse_cycles = ghrd_pkg::cold_pulse_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req_in,
  output logic pulse
);

  // counter must hold pulse_cycles itself
  localparam int unsigned count_width = $clog2(pulse_cycles + 1);
  localparam logic [count_width-1:0] count_load = count_width'(pulse_cycles);

  // ==========================================================================
  // edge detect
  // ==========================================================================
  logic                   req_d;      // req_in one cycle ago
  logic                   req_rise;
  logic [count_width-1:0] pulse_cnt;  // remaining pulse cycles

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_d <= 1'b1;  // a level held through reset is not an edge
    end
    else
    begin
      req_d <= req_in;
    end
  end

  assign req_rise = req_in & ~req_d;

  // ==========================================================================
  // pulse stretcher
  // ==========================================================================

  // load only from idle, so a busy counter ignores new edges
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      pulse_cnt <= '0;
    end
    else if (pulse_cnt != '0)
    begin
      pulse_cnt <= pulse_cnt - 1'b1;  // running
    end
    else if (req_rise)
    begin
      pulse_cnt <= count_load;        // start, high from next cycle
    end
  end

  // high exactly pulse_cycles cycles per accepted edge
  assign pulse = (pulse_cnt != '0);

endmodule

// ==== hw/heartbeat_led.sv ====
// free-running heartbeat for an LED
// led_level starts at 0 and toggles every heartbeat_half_period cycles
// heartbeat_half_period must be at least 1

`timescale 1ns/1ps

module heartbeat_led #(
  parameter int unsigned heartbeat_half_period = ghrd_pkg::default_heartbeat_half_period
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led_level
);

  localparam int unsigned count_width = $clog2(heartbeat_half_period + 1);
  localparam logic [count_width-1:0] count_wrap =
    count_width'(heartbeat_half_period - 1);

  logic [count_width-1:0] half_cnt;  // cycles into current half period

  // wrap counter, flips the LED on each wrap
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      half_cnt  <= '0;
      led_level <= 1'b0;
    end
    else if (half_cnt == count_wrap)
    begin
      half_cnt  <= '0;
      led_level <= ~led_level;  // first flip heartbeat_half_period cycles after reset
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

// ==== hw/fabric_top.sv ====
// fabric logic beside the HPS on the board top level
// all logic on fpga_clk_50, async active-low reset from the HPS
// key is asynchronous and gets synchronized in key_debounce
// sw and hps_reset_req are taken as synchronous to fpga_clk_50
// hps_reset_req_n fields are active low, high while idle

`timescale 1ns/1ps

module fabric_top #(
  parameter int unsigned debounce_cycles       = ghrd_pkg::default_debounce_cycles,
  parameter int unsigned heartbeat_half_period = ghrd_pkg::default_heartbeat_half_period
) (
  input  logic                              fpga_clk_50,
  input  logic                              hps_fpga_reset_n,
  input  ghrd_pkg::key_vec_t                key,
  input  logic [ghrd_pkg::num_switches-1:0] sw,
  input  ghrd_pkg::hps_reset_req_t          hps_reset_req,
  output ghrd_pkg::key_vec_t                key_clean,
  output ghrd_pkg::hps_reset_req_t          hps_reset_req_n,
  output logic                              ledr_heartbeat,
  output ghrd_pkg::stm_event_t              stm_hw_events
);

  import ghrd_pkg::*;

  key_vec_t key_db;       // debounced keys, 0 = pressed
  logic     cold_pulse;   // active-high request pulses
  logic     warm_pulse;
  logic     debug_pulse;

  // ==========================================================================
  // keys
  // ==========================================================================
  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) key_debounce_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .debounced_key    (key_db)
  );

  assign key_clean = key_db;

  // ==========================================================================
  // HPS reset requests
  // ==========================================================================
  reset_pulse_gen #(
    .pulse_cycles (cold_pulse_cycles)
  ) cold_pulse_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_in           (hps_reset_req.cold),
    .pulse            (cold_pulse)
  );

  reset_pulse_gen #(
    .pulse_cycles (warm_pulse_cycles)
  ) warm_pulse_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_in           (hps_reset_req.warm),
    .pulse            (warm_pulse)
  );

  reset_pulse_gen #(
    .pulse_cycles (debug_pulse_cycles)
  ) debug_pulse_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req_in           (hps_reset_req.debug),
    .pulse            (debug_pulse)
  );

  // reset manager inputs are active low
  assign hps_reset_req_n = '{cold: ~cold_pulse, warm: ~warm_pulse, debug: ~debug_pulse};

  // ==========================================================================
  // heartbeat
  // ==========================================================================
  heartbeat_led #(
    .heartbeat_half_period (heartbeat_half_period)
  ) heartbeat_led_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_level        (ledr_heartbeat)
  );

  // ==========================================================================
  // STM event word
  // ==========================================================================

  // one register stage, switches and keys land together
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      stm_hw_events <= '0;
    end
    else
    begin
      stm_hw_events <= '{switches: sw, keys: key_db};
    end
  end

endmodule

// ==== dv/tb_checks.svh ====
// typed compare tasks and result counters for the fabric_top testbench
// included inside the testbench module, after the ghrd_pkg import
// every task prints one line, ok or [ERROR], and bumps a counter
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  int unsigned pass_count = 0;
  int unsigned fail_count = 0;

  // failures that have no single value to compare
  task automatic report_failure(string msg);
    fail_count++;
    $display("failure: %s", msg);
  endtask

  // ==========================================================================
  // one compare task per result type
  // ==========================================================================
  task automatic check_key(string test, key_vec_t want, key_vec_t got);
    if (got !== want)
    begin
      fail_count++;
      $display("[ERROR] key_clean expected 0x%h got 0x%h (%s)", want, got, test);
    end
    else
    begin
      pass_count++;
      $display("ok  %s: key_clean = 0x%h", test, got);
    end
  endtask

  task automatic check_req(string test, hps_reset_req_t want, hps_reset_req_t got);
    if (got !== want)
    begin
      fail_count++;
      $display("[ERROR] hps_reset_req_n expected 0x%h got 0x%h (%s)", want, got, test);
    end
    else
    begin
      pass_count++;
      $display("ok  %s: hps_reset_req_n = 0x%h", test, got);
    end
  endtask

  task automatic check_events(string test, stm_event_t want, stm_event_t got);
    if (got !== want)
    begin
      fail_count++;
      $display("[ERROR] stm_hw_events expected 0x%h got 0x%h (%s)", want, got, test);
    end
    else
    begin
      pass_count++;
      $display("ok  %s: stm_hw_events = 0x%h", test, got);
    end
  endtask

  task automatic check_led(string test, logic want, logic got);
    if (got !== want)
    begin
      fail_count++;
      $display("[ERROR] ledr_heartbeat expected 0x%h got 0x%h (%s)", want, got, test);
    end
    else
    begin
      pass_count++;
      $display("ok  %s: ledr_heartbeat = 0x%h", test, got);
    end
  endtask

  // counted results, e.g. LED edges in a window
  task automatic check_count(string test, string what, int unsigned want, int unsigned got);
    if (got != want)
    begin
      fail_count++;
      $display("[ERROR] %s expected 0x%h got 0x%h (%s)", what, want, got, test);
    end
    else
    begin
      pass_count++;
      $display("ok  %s: %s = 0x%h", test, what, got);
    end
  endtask

`endif

// ==== dv/fabric_top_tb.sv ====
// testbench for fabric_top with short debounce (16) and heartbeat (10) periods
// inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
// rows of stim_table run back to back and each takes exactly its hold cycles
// a cycle limit from the table length stops a stuck run

`timescale 1ns/1ps

module fabric_top_tb;

  import ghrd_pkg::*;

  localparam int unsigned tb_debounce_cycles = 16;
  localparam int unsigned tb_heartbeat_half  = 10;
  localparam int unsigned glitch_max         = 8;    // glitch lengths stay below
  localparam int unsigned retrig_at          = 8;    // second debug edge, cycles in
  localparam int unsigned led_window         = 100;
  localparam int unsigned num_rows           = 13;

  typedef enum int unsigned {
    act_key_level,
    act_key_glitch,
    act_reset_req,
    act_req_retrigger,
    act_switch
  } action_e;

  typedef struct {
    action_e     action;
    logic [31:0] operand;   // key level, key index, reset kind or switch value
    int unsigned hold;      // cycles the row takes
    logic [31:0] expected;  // key level, pulse length or event word
  } stim_row_t;

  logic                    fpga_clk_50;
  logic                    hps_fpga_reset_n;
  key_vec_t                key;
  logic [num_switches-1:0] sw;
  hps_reset_req_t          hps_reset_req;
  key_vec_t                key_clean;
  hps_reset_req_t          hps_reset_req_n;
  logic                    ledr_heartbeat;
  stm_event_t              stm_hw_events;

  stim_row_t   stim_table [num_rows];
  int unsigned timeout_limit = 0;      // 0 until the table exists
  int unsigned cycle_count;

  `include "tb_checks.svh"

  fabric_top #(
    .debounce_cycles       (tb_debounce_cycles),
    .heartbeat_half_period (tb_heartbeat_half)
  ) fabric_top_inst (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .sw               (sw),
    .hps_reset_req    (hps_reset_req),
    .key_clean        (key_clean),
    .hps_reset_req_n  (hps_reset_req_n),
    .ledr_heartbeat   (ledr_heartbeat),
    .stm_hw_events    (stm_hw_events)
  );

  always #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period

  // ==========================================================================
  // stimulus table
  // ==========================================================================
  function automatic stim_row_t make_row(action_e action, logic [31:0] operand,
                                         int unsigned hold, logic [31:0] expected);
    stim_row_t row;
    row.action   = action;
    row.operand  = operand;
    row.hold     = hold;
    row.expected = expected;
    return row;
  endfunction

  // random switches with keys as the table left them
  function automatic stim_row_t switch_row(key_vec_t keys);
    stm_event_t ev;
    ev.switches = num_switches'($urandom);
    ev.keys     = keys;
    return make_row(act_switch, 32'(ev.switches), 2, 32'(ev));
  endfunction

  task automatic build_table();
    stim_table[0]  = make_row(act_key_level, 32'h0e, 24, 32'h0e);  // press key0
    stim_table[1]  = switch_row(4'he);
    stim_table[2]  = make_row(act_key_glitch, 32'd1, 30, 32'h0e);  // key1 bounces
    stim_table[3]  = make_row(act_key_glitch, 32'd0, 30, 32'h0e);  // held key bounces
    stim_table[4]  = switch_row(4'he);
    stim_table[5]  = make_row(act_reset_req, 32'(reset_cold), 10, 32'd6);
    stim_table[6]  = make_row(act_reset_req, 32'(reset_warm), 6, 32'd2);
    stim_table[7]  = make_row(act_reset_req, 32'(reset_debug), 36, 32'd32);
    stim_table[8]  = make_row(act_req_retrigger, 32'(reset_debug), 36, 32'd32);
    stim_table[9]  = make_row(act_key_level, 32'h06, 24, 32'h06);  // add key3
    stim_table[10] = switch_row(4'h6);
    stim_table[11] = make_row(act_key_level, 32'h0f, 24, 32'h0f);  // release all
    stim_table[12] = switch_row(4'hf);
  endtask

  // ==========================================================================
  // row actions
  // ==========================================================================
  task automatic step_to_drive();
    @(posedge fpga_clk_50);
    #1;
  endtask

  // new key level must settle within debounce_cycles .. debounce_cycles+4
  task automatic press_keys(string name, stim_row_t row);
    key_vec_t    want;
    int unsigned used;
    int unsigned seen;
    want = key_vec_t'(row.expected);
    used = 0;
    seen = 0;
    key  = key_vec_t'(row.operand);
    while (seen == 0 && used < tb_debounce_cycles + 4)
    begin
      used++;
      step_to_drive();
      @(negedge fpga_clk_50);
      if (key_clean === want)
      begin
        seen = used;
      end
    end
    if (seen == 0)
      report_failure($sformatf("%s: key_clean never settled within %0d cycles", name, used));
    else if (seen < tb_debounce_cycles)
      report_failure($sformatf("%s: key_clean settled after only %0d cycles", name, seen));
    check_key(name, want, key_clean);
    repeat (row.hold - used) step_to_drive();
  endtask

  // short flip of one key that key_clean must not follow
  task automatic bounce_key(string name, stim_row_t row);
    key_vec_t    got;
    int unsigned len;
    int unsigned idx;
    logic        moved;
    idx   = row.operand;
    len   = 1 + ($urandom % (glitch_max - 1));  // 1 .. 7 cycles
    got   = key_vec_t'(row.expected);
    moved = 1'b0;
    key[idx] = ~key[idx];
    for (int unsigned n = 1; n <= row.hold; n++)
    begin
      @(negedge fpga_clk_50);
      if (!moved && key_clean !== key_vec_t'(row.expected))
      begin
        moved = 1'b1;  // keep first wrong value
        got   = key_clean;
      end
      step_to_drive();
      if (n == len)
        key[idx] = ~key[idx];  // bounce over
    end
    check_key($sformatf("%s len %0d", name, len), key_vec_t'(row.expected), got);
  endtask

  // rising request gives a low field on samples 1 .. len only
  task automatic pulse_request(string name, stim_row_t row, int unsigned retrig);
    logic [2:0]     mask;
    hps_reset_req_t want;
    hps_reset_req_t bad_want;
    hps_reset_req_t bad_got;
    int unsigned    len;
    int unsigned    bad_k;
    logic           bad;
    mask     = 3'(3'b001 << row.operand[1:0]);  // kind is the bit position
    len      = row.expected;
    bad      = 1'b0;
    bad_k    = 0;
    bad_want = '1;
    bad_got  = '1;
    hps_reset_req = hps_reset_req_t'(hps_reset_req | mask);
    for (int unsigned k = 0; k < row.hold; k++)
    begin
      @(negedge fpga_clk_50);
      want = '1;  // idle level is all high
      if (k >= 1 && k <= len)
        want = hps_reset_req_t'(~mask);
      if (!bad && hps_reset_req_n !== want)
      begin
        bad      = 1'b1;
        bad_k    = k;
        bad_want = want;
        bad_got  = hps_reset_req_n;
      end
      step_to_drive();
      if (retrig != 0 && k + 1 == retrig / 2)
        hps_reset_req = hps_reset_req_t'(hps_reset_req & ~mask);
      if (retrig != 0 && k + 1 == retrig)
        hps_reset_req = hps_reset_req_t'(hps_reset_req | mask);  // edge mid-pulse
      if (k + 1 == len + 1)
        hps_reset_req = hps_reset_req_t'(hps_reset_req & ~mask);
    end
    if (bad)
      check_req($sformatf("%s cycle %0d", name, bad_k), bad_want, bad_got);
    else
      check_req(name, bad_want, bad_got);
  endtask

  // event word one cycle after the switches change
  task automatic set_switches(string name, stim_row_t row);
    sw = num_switches'(row.operand);
    step_to_drive();
    @(negedge fpga_clk_50);
    check_events(name, stm_event_t'(row.expected[$bits(stm_event_t)-1:0]), stm_hw_events);
    repeat (row.hold - 1) step_to_drive();
  endtask

  task automatic apply_row(int unsigned idx);
    stim_row_t row;
    string     name;
    row  = stim_table[idx];
    name = $sformatf("row %0d %s", idx, row.action.name());
    case (row.action)
      act_key_level:     press_keys(name, row);
      act_key_glitch:    bounce_key(name, row);
      act_reset_req:     pulse_request(name, row, 0);
      act_req_retrigger: pulse_request(name, row, retrig_at);
      default:           set_switches(name, row);
    endcase
  endtask

  // heartbeat edges in a fixed window
  task automatic count_led_edges();
    logic        prev;
    int unsigned edges;
    edges = 0;
    @(negedge fpga_clk_50);
    prev = ledr_heartbeat;
    repeat (led_window)
    begin
      @(negedge fpga_clk_50);
      if (ledr_heartbeat !== prev)
        edges++;
      prev = ledr_heartbeat;
    end
    check_count("heartbeat", "ledr_heartbeat edges", led_window / tb_heartbeat_half, edges);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial
  begin
    int unsigned hold_sum;
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;
    key              = '1;  // released
    sw               = '0;
    hps_reset_req    = '0;
    void'($urandom(32'he30a_63c0));
    build_table();
    hold_sum = 0;
    for (int unsigned i = 0; i < num_rows; i++)
      hold_sum += stim_table[i].hold;
    timeout_limit = hold_sum + 20 * tb_debounce_cycles + 100;

    repeat (2) @(posedge fpga_clk_50);
    #1;
    hps_fpga_reset_n = 1'b1;
    @(negedge fpga_clk_50);  // before the first clocked update
    check_key("reset state", '1, key_clean);
    check_req("reset state", '1, hps_reset_req_n);
    check_led("reset state", 1'b0, ledr_heartbeat);
    check_events("reset state", '0, stm_hw_events);
    step_to_drive();

    for (int unsigned r = 0; r < num_rows; r++)
      apply_row(r);
    count_led_edges();

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // cycle limit
  initial
  begin
    cycle_count = 0;
    wait (timeout_limit != 0);
    while (cycle_count < timeout_limit)
    begin
      @(posedge fpga_clk_50);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_count);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+dv
hw/ghrd_pkg.sv
hw/key_debounce.sv
hw/reset_pulse_gen.sv
hw/heartbeat_led.sv
hw/fabric_top.sv
dv/fabric_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the fabric_top testbench

TOP := fabric_top_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and scan $(LOG) for a failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/V$(TOP): verilog.f $(wildcard hw/*.sv dv/*.sv dv/*.svh)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
